// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Width of the major opcode field at the bottom of every instruction
    localparam int OPCODE_W = 7;

    typedef logic [31:0]         instr_t;   // One fetched instruction word
    typedef logic [OPCODE_W-1:0] opcode_t;  // Major opcode, bits [6:0] of a word

    // SYSTEM major opcode. The front end treats every word with this
    // opcode as URET, since no other system instruction is supported
    localparam opcode_t OPCODE_SYSTEM = 7'h73;

    localparam opcode_t OPCODE_OP_IMM = 7'h13;  // ADDI and the other immediate ALU ops

endpackage

`default_nettype wire

// File: hw/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    typedef logic [11:0] addr_t;         // Byte address of an instruction
    typedef logic [2:0]  drain_count_t;  // Pipeline drain counter

    localparam drain_count_t DRAIN_FIRST = 3'd1;  // Counter value right after a drain starts
    localparam drain_count_t DRAIN_LAST  = 3'd4;  // Drain ends on the next enabled edge

    localparam addr_t ISR_VECTOR = 12'h100;  // Entry of the interrupt service routine
    localparam addr_t FETCH_STEP = 12'd4;    // One instruction word

    localparam int ROM_WORDS = 1024;  // Covers the whole 12-bit byte address space

    // Redirects driven by the back end of the pipeline
    typedef struct packed {
        logic [1:0] exe_correction;  // Nonzero when execute corrects a branch
        addr_t      exe_target;
        logic       id_jump;         // Decode found an unconditional jump
        addr_t      id_target;
        logic       prediction;      // Predictor says taken
        addr_t      pred_target;
    } redirect_t;

    // Interrupt controller outputs toward the PC unit
    typedef struct packed {
        logic  enter;    // One cycle, fetch goes to ISR_VECTOR
        logic  ret;      // One cycle, fetch goes to save_pc
        logic  stall;    // Hold sequential fetch while the pipeline drains
        logic  in_isr;   // Service routine is running
        addr_t save_pc;  // Address to return to after the routine
    } isr_ctrl_t;

endpackage

`default_nettype wire

// File: hw/interrupt_controller.sv
`timescale 1ns/10ps
`default_nettype none

module interrupt_controller (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    irq_n,
    input  frontend_pkg::addr_t     pc,
    input  isa_pkg::opcode_t        opcode,
    input  frontend_pkg::redirect_t redirect,
    input  logic                    if_clk_en,
    output frontend_pkg::isr_ctrl_t isr_ctrl
);
    import isa_pkg::*;
    import frontend_pkg::*;

    logic         armed;         // Ready to accept the external interrupt
    logic         in_isr;
    drain_count_t drain_cnt;
    logic         enter_q;
    logic         ret_q;
    logic         save_pending;  // A redirect was seen while stalling
    addr_t        save_pc_q;

    logic         uret_fetch;
    logic         draining;
    logic         drain_done;
    logic         redirect_any;
    logic         take_irq;
    logic         take_uret;
    logic         stall;

    assign uret_fetch   = (opcode == OPCODE_SYSTEM);
    assign draining     = (drain_cnt != '0);
    assign drain_done   = (drain_cnt == DRAIN_LAST) && if_clk_en;  // Frozen while fetch is held
    assign redirect_any = (redirect.exe_correction != 2'b00) ||
                          redirect.id_jump ||
                          redirect.prediction;

    assign take_irq  = armed && !irq_n;  // Armed only outside a routine with no drain
    // Only a URET inside the routine starts a return drain. In the ret cycle
    // in_isr is already low, so the URET word still at pc is not taken again
    assign take_uret = uret_fetch && in_isr && !draining;

    assign stall = draining || uret_fetch;  // URET stalls in the same cycle it is fetched

    always_ff @(posedge clk) begin
        if (!nrst) begin
            armed        <= 1'b1;
            in_isr       <= 1'b0;
            drain_cnt    <= '0;
            enter_q      <= 1'b0;
            ret_q        <= 1'b0;
            save_pending <= 1'b0;
        end else begin
            enter_q      <= 1'b0;  // Both pulses last a single cycle
            ret_q        <= 1'b0;
            save_pending <= stall && redirect_any;

            if (take_irq || take_uret) begin
                drain_cnt <= DRAIN_FIRST;
            end else if (drain_done) begin
                drain_cnt <= '0;
                if (in_isr) begin
                    in_isr <= 1'b0;  // Leaving the routine
                    ret_q  <= 1'b1;
                    armed  <= 1'b1;  // Next interrupt may now be taken
                end else begin
                    in_isr  <= 1'b1;
                    enter_q <= 1'b1;
                end
            end else if (draining && if_clk_en) begin
                drain_cnt <= drain_cnt + DRAIN_FIRST;
            end

            if (take_irq) begin
                armed <= 1'b0;
            end
        end
    end

    // A redirect taken while stalling lands in pc one cycle later, so the
    // capture is delayed by one edge to pick up the new target
    always_ff @(posedge clk) begin
        if (take_irq || save_pending) begin
            save_pc_q <= pc;
        end
    end

    assign isr_ctrl = isr_ctrl_t'{
        enter:   enter_q,
        ret:     ret_q,
        stall:   stall,
        in_isr:  in_isr,
        save_pc: save_pc_q
    };

endmodule

`default_nettype wire

// File: hw/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    if_clk_en,
    input  frontend_pkg::redirect_t redirect,
    input  frontend_pkg::isr_ctrl_t isr_ctrl,
    output frontend_pkg::addr_t     pc
);
    import frontend_pkg::*;

    addr_t pc_next;
    addr_t pc_seq;
    logic  advance;

    assign pc_seq  = pc + FETCH_STEP;
    assign advance = if_clk_en && !isr_ctrl.stall;  // Sequential fetch only when not draining

    // Interrupt pulses outrank every back-end redirect. Redirects still
    // apply during a stall so the drain can follow a late branch
    always_comb begin
        if (isr_ctrl.ret) begin
            pc_next = isr_ctrl.save_pc;
        end else if (isr_ctrl.enter) begin
            pc_next = ISR_VECTOR;
        end else if (redirect.exe_correction != 2'b00) begin
            pc_next = redirect.exe_target;  // Execute knows best, oldest instruction
        end else if (redirect.id_jump) begin
            pc_next = redirect.id_target;
        end else if (redirect.prediction) begin
            pc_next = redirect.pred_target;
        end else if (advance) begin
            pc_next = pc_seq;
        end else begin
            pc_next = pc;  // Held by back-pressure or stall
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/instr_rom.sv
`timescale 1ns/10ps
`default_nettype none

module instr_rom (
    input  frontend_pkg::addr_t pc,
    output isa_pkg::instr_t     instr
);
    import isa_pkg::*;
    import frontend_pkg::*;

    localparam int INDEX_W = $clog2(ROM_WORDS);

    instr_t             mem [ROM_WORDS];
    logic [INDEX_W-1:0] word_index;

    // Image holds the main program and the service routine at ISR_VECTOR
    initial begin
        $readmemh("testbench/program.hex", mem);
    end

    assign word_index = pc[INDEX_W+1:2];  // Word address, byte offset dropped
    assign instr      = mem[word_index];  // Asynchronous read in the fetch cycle

endmodule

`default_nettype wire

// File: hw/frontend_top.sv
`timescale 1ns/10ps
`default_nettype none

module frontend_top (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    irq_n,
    input  logic                    if_clk_en,
    input  frontend_pkg::redirect_t redirect,
    output frontend_pkg::addr_t     pc,
    output isa_pkg::instr_t         instr,
    output frontend_pkg::isr_ctrl_t isr_ctrl
);
    import isa_pkg::*;

    opcode_t fetch_opcode;

    assign fetch_opcode = instr[OPCODE_W-1:0];  // Controller only looks for URET

    pc_unit u_pc_unit (
        .clk       (clk),
        .nrst      (nrst),
        .if_clk_en (if_clk_en),
        .redirect  (redirect),
        .isr_ctrl  (isr_ctrl),
        .pc        (pc)
    );

    instr_rom u_instr_rom (
        .pc    (pc),
        .instr (instr)
    );

    // Sees the same redirects as the PC unit to track the return address
    interrupt_controller u_interrupt_controller (
        .clk       (clk),
        .nrst      (nrst),
        .irq_n     (irq_n),
        .pc        (pc),
        .opcode    (fetch_opcode),
        .redirect  (redirect),
        .if_clk_en (if_clk_en),
        .isr_ctrl  (isr_ctrl)
    );

endmodule

`default_nettype wire

// File: testbench/frontend_properties.sv
`timescale 1ns/10ps
`default_nettype none

module frontend_properties (
    input logic                    clk,
    input logic                    nrst,
    input frontend_pkg::isr_ctrl_t isr_ctrl
);

    // Entry and return never overlap since only one drain runs at a time
    pulses_exclusive: assert property (
        @(posedge clk) disable iff (!nrst)
        !(isr_ctrl.enter && isr_ctrl.ret)
    ) else $error("enter and ret are high in the same cycle");

    enter_one_cycle: assert property (
        @(posedge clk) disable iff (!nrst)
        isr_ctrl.enter |=> !isr_ctrl.enter
    ) else $error("enter lasted longer than one cycle");

    ret_one_cycle: assert property (
        @(posedge clk) disable iff (!nrst)
        isr_ctrl.ret |=> !isr_ctrl.ret
    ) else $error("ret lasted longer than one cycle");

    // The last drain cycle always stalls fetch
    stall_before_enter: assert property (
        @(posedge clk) disable iff (!nrst)
        isr_ctrl.enter |-> $past(isr_ctrl.stall)
    ) else $error("enter came without a stall in the cycle before");

    in_isr_with_enter: assert property (
        @(posedge clk) disable iff (!nrst)
        $rose(isr_ctrl.in_isr) |-> isr_ctrl.enter
    ) else $error("in_isr rose without an enter pulse");

endmodule

bind interrupt_controller frontend_properties u_frontend_properties (
    .clk      (clk),
    .nrst     (nrst),
    .isr_ctrl (isr_ctrl)
);

`default_nettype wire

// File: testbench/frontend_tb.sv
`timescale 1ns/10ps
`default_nettype none

module frontend_tb;
    import isa_pkg::*;
    import frontend_pkg::*;

    localparam int     NUM_TESTS    = 9;
    localparam int     RESET_CYCLES = 5;
    localparam int     MARGIN       = 100;
    localparam addr_t  URET_ADDR    = ISR_VECTOR + 12'd12;  // Fourth word of the routine
    localparam instr_t ADDI_WORD    = 32'h0010_8093;        // addi x1, x1, 1
    localparam instr_t URET_WORD    = 32'h0020_0073;

    typedef struct packed {
        int irq_cycle;     // First cycle with irq_n low, -1 for none
        int irq_len;
        int irq2_cycle;    // One more low cycle later on, -1 for none
        int redir_cycle;
        int redir_kind;    // 0 correction, 1 jump, 2 prediction
        int redir_target;
        int gap_cycle;
        int gap_len;
        int rand_en;       // Random if_clk_en instead of the gap
        int length;
        int exp_save;      // -1 skips the check
        int exp_return;
        int exp_stall;     // Stall cycles before the first entry
        int exp_enters;
    } test_row_t;

    logic      clk;
    logic      nrst;
    logic      irq_n;
    logic      if_clk_en;
    redirect_t redirect;
    addr_t     pc;
    instr_t    instr;
    isr_ctrl_t isr_ctrl;

    test_row_t rows [NUM_TESTS];
    string     names [NUM_TESTS];
    string     cur_name;
    int        seed;
    int        cycle_count = 0;
    int        timeout_limit = 0;
    int        errors = 0;
    int        failed_tests = 0;

    addr_t        m_pc;  // Reference model state
    addr_t        m_save;
    logic         m_save_valid;
    logic         m_armed;
    logic         m_in_isr;
    logic         m_enter;
    logic         m_ret;
    logic         m_pending;
    drain_count_t m_cnt;

    frontend_top u_frontend_top (
        .clk       (clk),
        .nrst      (nrst),
        .irq_n     (irq_n),
        .if_clk_en (if_clk_en),
        .redirect  (redirect),
        .pc        (pc),
        .instr     (instr),
        .isr_ctrl  (isr_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run went past %0d cycles", timeout_limit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic load_table();
        // irq len irq2 rcyc kind target gap glen rand len save ret stall enters
        rows[0] = '{-1, 0, -1, -1, 0, 'h000, 4, 3, 0, 14, -1, -1, -1, 0};
        rows[1] = '{2, 1, -1, -1, 0, 'h000, -1, 0, 0, 24, 'h008, 'h008, 4, 1};
        rows[2] = '{3, 1, -1, 5, 0, 'h040, -1, 0, 0, 26, 'h040, 'h040, 4, 1};
        rows[3] = '{4, 1, -1, 7, 1, 'h080, -1, 0, 0, 26, 'h080, 'h080, 4, 1};
        rows[4] = '{2, 1, -1, 6, 2, 'h0c0, -1, 0, 0, 24, 'h0c0, 'h0c0, 4, 1};
        rows[5] = '{5, 1, -1, -1, 0, 'h000, -1, 0, 0, 26, 'h014, 'h014, 4, 1};
        rows[6] = '{3, 1, -1, -1, 0, 'h000, 5, 3, 0, 30, 'h00c, 'h00c, 7, 1};
        rows[7] = '{3, 12, 20, -1, 0, 'h000, -1, 0, 0, 40, 'h00c, 'h00c, 4, 2};
        rows[8] = '{4, 1, -1, -1, 0, 'h000, -1, 0, 1, 60, -1, -1, -1, -1};
        names[0] = "sequential_fetch";
        names[1] = "interrupt_entry";
        names[2] = "redirect_correction";
        names[3] = "redirect_jump";
        names[4] = "redirect_prediction";
        names[5] = "uret_return";
        names[6] = "fetch_enable_gap";
        names[7] = "ignored_interrupt";
        names[8] = "random_enable";
    endtask

    task automatic check_value(string what, int exp, int act);
        assert (exp == act) else begin
            $display("Error %s %s: expected 'h%0h, actual 'h%0h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic model_reset();
        m_pc         = '0;
        m_save       = '0;
        m_save_valid = 1'b0;  // save_pc holds no value until the first capture
        m_armed      = 1'b1;
        m_in_isr     = 1'b0;
        m_enter      = 1'b0;
        m_ret        = 1'b0;
        m_pending    = 1'b0;
        m_cnt        = '0;
    endtask

    function automatic logic model_stall();
        return (m_cnt != '0) || (m_pc == URET_ADDR);
    endfunction

    // Advances the model by one rising edge with the inputs now driven
    task automatic model_step();
        logic  draining;
        logic  stall;
        logic  redir;
        logic  done;
        logic  take_irq;
        logic  take_uret;
        addr_t pc_nx;
        addr_t save_nx;
        draining  = (m_cnt != '0);
        stall     = model_stall();
        redir     = (redirect.exe_correction != 2'b00) || redirect.id_jump || redirect.prediction;
        done      = (m_cnt == DRAIN_LAST) && if_clk_en;
        take_irq  = m_armed && !irq_n;
        take_uret = (m_pc == URET_ADDR) && m_in_isr && !draining;
        if (m_ret) begin
            pc_nx = m_save;
        end else if (m_enter) begin
            pc_nx = ISR_VECTOR;
        end else if (redirect.exe_correction != 2'b00) begin
            pc_nx = redirect.exe_target;
        end else if (redirect.id_jump) begin
            pc_nx = redirect.id_target;
        end else if (redirect.prediction) begin
            pc_nx = redirect.pred_target;
        end else if (!stall && if_clk_en) begin
            pc_nx = m_pc + 12'd4;
        end else begin
            pc_nx = m_pc;
        end
        save_nx = (take_irq || m_pending) ? m_pc : m_save;  // Redirect target is in pc one edge on
        m_save_valid = m_save_valid || take_irq;
        m_pending = stall && redir;
        m_enter   = 1'b0;
        m_ret     = 1'b0;
        if (take_irq || take_uret) begin
            m_cnt = 3'd1;
        end else if (done) begin
            m_cnt = '0;
            if (m_in_isr) begin
                m_in_isr = 1'b0;
                m_ret    = 1'b1;
                m_armed  = 1'b1;
            end else begin
                m_in_isr = 1'b1;
                m_enter  = 1'b1;
            end
        end else if (draining && if_clk_en) begin
            m_cnt = m_cnt + 3'd1;
        end
        if (take_irq) begin
            m_armed = 1'b0;
        end
        m_pc   = pc_nx;
        m_save = save_nx;
    endtask

    task automatic drive_idle();
        irq_n     = 1'b1;
        if_clk_en = 1'b1;
        redirect  = '0;
    endtask

    task automatic run_test(int idx);
        test_row_t row;
        int        enters;
        int        rets;
        int        stall_run;
        int        errors_before;
        int        rnd;
        logic      entered_prev;
        logic      ret_prev;
        logic      save_seen;
        instr_t    exp_instr;
        row           = rows[idx];
        cur_name      = names[idx];
        errors_before = errors;
        enters        = 0;
        rets          = 0;
        stall_run     = 0;
        entered_prev  = 1'b0;
        ret_prev      = 1'b0;
        save_seen     = 1'b0;

        @(negedge clk);
        nrst = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(negedge clk);
        nrst = 1'b1;
        model_reset();

        for (int c = 0; c < row.length; c++) begin
            exp_instr = (m_pc == URET_ADDR) ? URET_WORD : ADDI_WORD;
            check_value("pc", int'(m_pc), int'(pc));
            check_value("instr", int'(exp_instr), int'(instr));
            check_value("stall", int'(model_stall()), int'(isr_ctrl.stall));
            check_value("enter", int'(m_enter), int'(isr_ctrl.enter));
            check_value("ret", int'(m_ret), int'(isr_ctrl.ret));
            check_value("in_isr", int'(m_in_isr), int'(isr_ctrl.in_isr));
            if (m_save_valid) begin
                check_value("save_pc", int'(m_save), int'(isr_ctrl.save_pc));
            end
            if (entered_prev && row.exp_save >= 0) begin
                check_value("saved address", row.exp_save, int'(isr_ctrl.save_pc));
                save_seen = 1'b1;
            end
            if (ret_prev && row.exp_return >= 0) begin
                check_value("return address", row.exp_return, int'(pc));
            end
            if (isr_ctrl.stall && enters == 0) begin
                stall_run++;
            end
            if (isr_ctrl.enter) enters++;
            if (isr_ctrl.ret) rets++;
            entered_prev = isr_ctrl.enter && (enters == 1);
            ret_prev     = isr_ctrl.ret && (rets == 1);

            irq_n = !((row.irq_cycle >= 0 && c >= row.irq_cycle &&
                       c < row.irq_cycle + row.irq_len) || c == row.irq2_cycle);
            if (row.rand_en != 0) begin
                rnd       = $random(seed);
                if_clk_en = (rnd[1:0] != 2'b00);  // Enabled about three cycles in four
            end else begin
                if_clk_en = !(c >= row.gap_cycle && c < row.gap_cycle + row.gap_len);
            end
            redirect = '0;
            if (c == row.redir_cycle) begin
                case (row.redir_kind)
                    0: begin
                        redirect.exe_correction = 2'b01;
                        redirect.exe_target     = addr_t'(row.redir_target);
                    end
                    1: begin
                        redirect.id_jump   = 1'b1;
                        redirect.id_target = addr_t'(row.redir_target);
                    end
                    default: begin
                        redirect.prediction  = 1'b1;
                        redirect.pred_target = addr_t'(row.redir_target);
                    end
                endcase
            end
            model_step();
            @(negedge clk);
        end
        drive_idle();

        if (row.exp_stall >= 0) check_value("stall cycles", row.exp_stall, stall_run);
        if (row.exp_enters >= 0) check_value("entries", row.exp_enters, enters);
        if (row.exp_save >= 0) begin
            assert (save_seen) else begin
                $display("%s: the interrupt was never entered", cur_name);
                errors++;
            end
        end
        if (errors == errors_before) begin
            $display("Test %s: ok", cur_name);
        end else begin
            $display("Test %s: %0d errors", cur_name, errors - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        seed = 32'hc7e2_00e5;
        nrst = 1'b0;
        drive_idle();
        model_reset();
        load_table();
        for (int i = 0; i < NUM_TESTS; i++) begin
            timeout_limit += rows[i].length + RESET_CYCLES + 2;
        end
        timeout_limit += MARGIN;

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, errors);
        if (failed_tests == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/program.hex
// Eight instruction words per line, each ADDI x1, x1, 1 unless noted
// Main program from byte 0, service routine at byte 0x100 ending in URET at 0x10C
@00
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
@40
00108093 00108093 00108093 00200073 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093
00108093 00108093 00108093 00108093 00108093 00108093 00108093 00108093

// File: build.f
hw/isa_pkg.sv
hw/frontend_pkg.sv
hw/interrupt_controller.sv
hw/pc_unit.sv
hw/instr_rom.sv
hw/frontend_top.sv
testbench/frontend_properties.sv
testbench/frontend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the front-end testbench with Verilator.
# Exits nonzero when the build, the run or any check fails.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f build.f \
    --top-module frontend_tb \
    -o frontend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/frontend_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
